// ==== game_params.svh ====
/*
 * Sizes and timing constants of the piano game core.
 * Included by the package, the RTL blocks and the testbench so that
 * every width and the key-press timeout come from one place.
 */
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// Width of a note code, 0 is no note and 1 to 12 are the keys
`define NOTE_W 4

// Song index width, 32 notes
`define ADDR_W 5

// Number of note keys on the board
`define NUM_KEYS 12

// Width of the score counter
`define SCORE_W 8

// Clocks allowed for a key press before the game is lost
`define TIMEOUT_CYCLES 64

`endif

// ==== piano_pkg.sv ====
/*
 * Shared types of the piano game core.
 * Import it into modules that handle notes, song addresses or the
 * game state, the testbench uses the state enum for its messages.
 */
`include "game_params.svh"

package piano_pkg;

    // Note code as stored in the song and decoded from the keys
    typedef logic [`NOTE_W-1:0] note_t;

    // Song index, also used for the round and the song length
    typedef logic [`ADDR_W-1:0] addr_t;

    // Game controller states
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_KEY,
        CHECK,
        WON,
        LOST
    } game_state_t;

endpackage

// ==== step_if.sv ====
/*
 * Command and status link between the game FSM and the counters.
 * The FSM takes the ctrl side, the counter block takes the count side.
 */
`timescale 1ns/1ps

interface step_if;

    // Commands from the FSM
    logic clear_all;
    logic next_note;
    logic next_round;

    // Status from the counters
    logic round_end;
    logic last_round;
    logic timeout;

    modport ctrl (
        output clear_all, next_note, next_round,
        input  round_end, last_round, timeout
    );

    modport count (
        input  clear_all, next_note, next_round,
        output round_end, last_round, timeout
    );

endinterface

// ==== key_capture.sv ====
/*
 * Key front end of the piano game.
 * Turns the key vector into a note code and gives a one-cycle press
 * pulse for every new key-down. Keys must already be clean and synchronous.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module key_capture import piano_pkg::*; (
    input  logic                 clock,
    input  logic                 rst,
    input  logic [`NUM_KEYS-1:0] keys,
    output logic                 press,
    output note_t                note
);

    logic  any_down;
    logic  any_prev;
    note_t enc_note;

    assign any_down = |keys;

    // Priority encoder, the lowest key index wins
    always_comb begin
        enc_note = '0;
        for (int i = `NUM_KEYS - 1; i >= 0; i--) begin
            if (keys[i]) begin
                enc_note = note_t'(i + 1);
            end
        end
    end

    // Press only on the rising edge of any-key-down
    always_ff @(posedge clock) begin
        if (rst) begin
            any_prev <= 1'b0;
            press    <= 1'b0;
        end else begin
            any_prev <= any_down;
            press    <= any_down & ~any_prev;
        end
    end

    // Note is latched together with the press
    always_ff @(posedge clock) begin
        if (any_down && !any_prev) begin
            note <= enc_note;
        end
    end

endmodule

// ==== song_mem.sv ====
/*
 * Song RAM of the piano game.
 * A host loads and reads notes over a Wishbone classic slave port,
 * and the game reads the expected note through a registered port
 * that follows its address by one clock.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module song_mem import piano_pkg::*; (
    input  logic  clock,

    // Wishbone classic slave
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  logic  wb_we,
    input  addr_t wb_adr,
    input  note_t wb_dat_w,
    output note_t wb_dat_r,
    output logic  wb_ack,

    // Game read port
    input  addr_t rd_addr,
    output note_t rd_note
);

    localparam int DEPTH = 1 << `ADDR_W;

    note_t mem [0:DEPTH-1];
    logic  wb_req;

    assign wb_req = wb_cyc & wb_stb;

    // One ack per request, it falls by itself the clock after
    always_ff @(posedge clock) begin
        wb_ack <= wb_req & ~wb_ack;
    end

    // Host side, write and read on the edge that raises the ack
    always_ff @(posedge clock) begin
        if (wb_req && !wb_ack) begin
            if (wb_we) begin
                mem[wb_adr] <= wb_dat_w;
            end
            wb_dat_r <= mem[wb_adr];
        end
    end

    // Game side
    always_ff @(posedge clock) begin
        rd_note <= mem[rd_addr];
    end

    stb_in_cycle: assert property (@(posedge clock)
        wb_stb |-> wb_cyc)
        else $error("wb_stb raised outside a bus cycle");

endmodule

// ==== game_counters.sv ====
/*
 * Counters of the piano game.
 * Keeps the note address, the round, the score and the key timeout
 * timer, steered by the FSM commands and reporting the round status.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module game_counters import piano_pkg::*; (
    input  logic                clock,
    input  logic                rst,
    input  addr_t               song_len,
    step_if.count               step,
    output addr_t               addr,
    output addr_t               round,
    output logic [`SCORE_W-1:0] score
);

    localparam int TMR_W = $clog2(`TIMEOUT_CYCLES + 1);

    logic [TMR_W-1:0] timer;
    logic             advance;

    assign advance = step.next_note | step.next_round;

    always_ff @(posedge clock) begin
        if (rst || step.clear_all) begin
            addr  <= '0;
            round <= '0;
            score <= '0;
        end else begin
            if (step.next_round) begin
                addr  <= '0;
                round <= round + 1'b1;
            end else if (step.next_note) begin
                addr <= addr + 1'b1;
            end
            // Score holds at its maximum on long songs
            if (advance && score != '1) begin
                score <= score + 1'b1;
            end
        end
    end

    // Timeout timer, restarted on every step and held once it expires
    always_ff @(posedge clock) begin
        if (rst || step.clear_all || advance) begin
            timer <= '0;
        end else if (!step.timeout) begin
            timer <= timer + 1'b1;
        end
    end

    assign step.timeout    = (timer == TMR_W'(`TIMEOUT_CYCLES));
    assign step.round_end  = (addr == round);
    assign step.last_round = (round == addr_t'(song_len - 1'b1));

endmodule

// ==== note_judge.sv ====
/*
 * Note judge of the piano game.
 * Captures the played note while the FSM listens and compares it
 * with the expected note from the song RAM.
 */
`timescale 1ns/1ps

module note_judge import piano_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  press,
    input  note_t note,
    input  logic  listen,
    input  note_t expected,
    output note_t played_note,
    output logic  match
);

    logic take;

    // Presses outside the listen window are dropped
    assign take = press & listen;

    always_ff @(posedge clock) begin
        if (rst) begin
            played_note <= '0;
        end else if (take) begin
            played_note <= note;
        end
    end

    // A blank note never matches, even against an empty song slot
    assign match = (played_note == expected) && (played_note != '0);

endmodule

// ==== game_fsm.sv ====
/*
 * Game controller of the piano game.
 * Runs the rounds from start to a win or a loss, tells the judge when
 * to listen and steps the counters through the step link.
 * busy is high while a game runs, won and lost hold until the next start.
 */
`timescale 1ns/1ps

module game_fsm import piano_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  start,
    input  logic  press,
    input  logic  match,
    step_if.ctrl  step,
    output logic  listen,
    output logic  busy,
    output logic  won,
    output logic  lost
);

    game_state_t state;
    game_state_t state_next;

    always_comb begin
        state_next      = state;
        step.clear_all  = 1'b0;
        step.next_note  = 1'b0;
        step.next_round = 1'b0;

        unique case (state)
            IDLE, WON, LOST: begin
                if (start) begin
                    step.clear_all = 1'b1;
                    state_next     = FETCH;
                end
            end

            // One cycle for the registered RAM read
            FETCH: begin
                state_next = WAIT_KEY;
            end

            WAIT_KEY: begin
                if (press) begin
                    state_next = CHECK;
                end else if (step.timeout) begin
                    state_next = LOST;
                end
            end

            CHECK: begin
                if (!match) begin
                    state_next = LOST;
                end else if (step.round_end && step.last_round) begin
                    // Final note still counts toward the score
                    step.next_note = 1'b1;
                    state_next     = WON;
                end else if (step.round_end) begin
                    step.next_round = 1'b1;
                    state_next      = FETCH;
                end else begin
                    step.next_note = 1'b1;
                    state_next     = FETCH;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
            won   <= 1'b0;
            lost  <= 1'b0;
        end else begin
            state <= state_next;
            won   <= (state_next == WON);
            lost  <= (state_next == LOST);
        end
    end

    assign listen = (state == WAIT_KEY);
    assign busy   = (state == FETCH) || (state == WAIT_KEY) || (state == CHECK);

    fetch_fresh_timer: assert property (@(posedge clock) disable iff (rst)
        (state == FETCH) |-> !step.timeout)
        else $error("key timer not restarted on entry to FETCH");

endmodule

// ==== piano_game.sv ====
/*
 * Top level of the piano game core.
 * Connects key capture, song RAM, counters, note judge and the FSM.
 * The host loads the song over Wishbone, sets song_len and pulses start.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module piano_game import piano_pkg::*; (
    input  logic                 clock,
    input  logic                 rst,

    // Player and game setup
    input  logic [`NUM_KEYS-1:0] keys,
    input  logic                 start,
    input  addr_t                song_len,

    // Wishbone classic slave
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  addr_t                wb_adr,
    input  note_t                wb_dat_w,
    output note_t                wb_dat_r,
    output logic                 wb_ack,

    // Game status
    output logic                 busy,
    output logic                 won,
    output logic                 lost,
    output addr_t                round,
    output logic [`SCORE_W-1:0]  score,
    output note_t                expected_note,
    output note_t                played_note
);

    logic  press;
    note_t note;
    logic  listen;
    logic  match;
    addr_t addr;

    step_if step ();

    key_capture u_keys (
        .clock (clock),
        .rst   (rst),
        .keys  (keys),
        .press (press),
        .note  (note)
    );

    // Expected note comes straight from the game read port
    song_mem u_mem (
        .clock    (clock),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rd_addr  (addr),
        .rd_note  (expected_note)
    );

    game_counters u_cnt (
        .clock    (clock),
        .rst      (rst),
        .song_len (song_len),
        .step     (step.count),
        .addr     (addr),
        .round    (round),
        .score    (score)
    );

    note_judge u_judge (
        .clock       (clock),
        .rst         (rst),
        .press       (press),
        .note        (note),
        .listen      (listen),
        .expected    (expected_note),
        .played_note (played_note),
        .match       (match)
    );

    game_fsm u_fsm (
        .clock  (clock),
        .rst    (rst),
        .start  (start),
        .press  (press),
        .match  (match),
        .step   (step.ctrl),
        .listen (listen),
        .busy   (busy),
        .won    (won),
        .lost   (lost)
    );

endmodule

// ==== tb_piano_game.sv ====
/*
 * Self-checking testbench of the piano game core.
 * Loads a random song over Wishbone, plays correct, wrong, silent and
 * double-key games, and compares each outcome with a reference model.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module tb_piano_game import piano_pkg::*; ();

    localparam int CYCLE_LIMIT = 6 * 40 * 12 + 4 * `TIMEOUT_CYCLES;

    logic                 clock;
    logic                 rst;
    logic [`NUM_KEYS-1:0] keys;
    logic                 start;
    addr_t                song_len;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    addr_t                wb_adr;
    note_t                wb_dat_w;
    note_t                wb_dat_r;
    logic                 wb_ack;
    logic                 busy;
    logic                 won;
    logic                 lost;
    addr_t                round;
    logic [`SCORE_W-1:0]  score;
    note_t                expected_note;
    note_t                played_note;

    // Reference copy of the song and the planned key presses
    note_t                song_ref [0:31];
    logic [`NUM_KEYS-1:0] plan_masks [0:63];
    logic [7:0]           lfsr = 8'd76;
    int                   errors = 0;
    int                   cycles = 0;

    piano_game piano_game_inst (.*);

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Watchdog on the whole run
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d", errors);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [7:0] next_lfsr(input logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = next_lfsr(lfsr);
        end
    endtask

    // Lowest pressed key wins
    function automatic note_t lowest_note(input logic [`NUM_KEYS-1:0] mask);
        note_t n;
        n = '0;
        for (int i = 0; i < `NUM_KEYS; i++) begin
            if (mask[i] && n == '0) begin
                n = note_t'(i + 1);
            end
        end
        return n;
    endfunction

    function automatic logic [`NUM_KEYS-1:0] key_mask(input note_t n);
        logic [`NUM_KEYS-1:0] m;
        m = '0;
        m[n - 1'b1] = 1'b1;
        return m;
    endfunction

    // Expected {won, lost, round, score} from the round rule
    function automatic logic [14:0] predict_game(input int len, input int count);
        int         r;
        int         i;
        logic [7:0] sc;
        r  = 0;
        i  = 0;
        sc = '0;
        for (int k = 0; k < count; k++) begin
            if (lowest_note(plan_masks[k]) != song_ref[i]) begin
                return {1'b0, 1'b1, addr_t'(r), sc};
            end
            sc = sc + 8'd1;
            if (i == r) begin
                if (r == len - 1) begin
                    return {1'b1, 1'b0, addr_t'(r), sc};
                end
                r = r + 1;
                i = 0;
            end else begin
                i = i + 1;
            end
        end
        // Presses ran out, so the timer ends the game
        return {1'b0, 1'b1, addr_t'(r), sc};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wb_access(input logic we, input addr_t adr, input note_t dat,
                             output note_t rdata);
        int waited;
        waited = 0;
        @(negedge clock);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge clock);
        while (!wb_ack && waited < 8) begin
            @(negedge clock);
            waited++;
        end
        if (!wb_ack) begin
            $display("no wb_ack for the access to address %0d", adr);
            errors++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Hold a key mask for 3 cycles, then wait for the next WAIT_KEY or the end
    task automatic push_keys(input logic [`NUM_KEYS-1:0] mask);
        note_t prev;
        int    stable;
        @(negedge clock);
        keys = mask;
        repeat (3) @(negedge clock);
        keys   = '0;
        stable = 0;
        prev   = expected_note;
        while (busy && stable < 2) begin
            @(negedge clock);
            if (expected_note == prev) begin
                stable++;
            end else begin
                stable = 0;
            end
            prev = expected_note;
        end
    endtask

    task automatic fill_correct(input int len, output int count);
        count = 0;
        for (int r = 0; r < len; r++) begin
            for (int i = 0; i <= r; i++) begin
                plan_masks[count] = key_mask(song_ref[i]);
                count++;
            end
        end
    endtask

    task automatic run_game(input int len, input int count, input logic hint,
                            output int elapsed);
        @(negedge clock);
        song_len = addr_t'(len);
        start    = 1'b1;
        @(negedge clock);
        start = 1'b0;
        check_value("busy", 32'(busy), 32'(1));
        check_value("won", 32'(won), 32'(0));
        check_value("lost", 32'(lost), 32'(0));
        check_value("score", 32'(score), 32'(0));
        @(negedge clock);
        elapsed = 2;
        for (int k = 0; k < count && busy; k++) begin
            if (hint) begin
                check_value("expected_note", 32'(expected_note),
                            32'(lowest_note(plan_masks[k])));
            end
            push_keys(plan_masks[k]);
            check_value("played_note", 32'(played_note), 32'(lowest_note(plan_masks[k])));
        end
        while (busy) begin
            @(negedge clock);
            elapsed++;
        end
    endtask

    task automatic expect_result(input int len, input int count);
        logic [14:0] pred;
        pred = predict_game(len, count);
        check_value("won", 32'(won), 32'(pred[14]));
        check_value("lost", 32'(lost), 32'(pred[13]));
        check_value("round", 32'(round), 32'(pred[12:8]));
        check_value("score", 32'(score), 32'(pred[7:0]));
    endtask

    initial begin
        logic [7:0] bits;
        note_t      got;
        note_t      wrong;
        int         count;
        int         elapsed;
        keys     = '0;
        start    = 1'b0;
        song_len = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rst      = 1'b1;
        repeat (4) @(negedge clock);
        rst = 1'b0;

        // Random song over Wishbone, then read back
        for (int a = 0; a < 8; a++) begin
            take_bits(4, bits);
            song_ref[a] = note_t'(bits % 8'd12 + 8'd1);
            wb_access(1'b1, addr_t'(a), song_ref[a], got);
        end
        for (int a = 0; a < 8; a++) begin
            wb_access(1'b0, addr_t'(a), '0, got);
            check_value("wb_dat_r", 32'(got), 32'(song_ref[a]));
        end

        // Presses while idle are dropped
        push_keys(12'h001);
        push_keys(12'h0C0);
        check_value("score", 32'(score), 32'(0));
        check_value("played_note", 32'(played_note), 32'(0));

        fill_correct(4, count);
        run_game(4, count, 1'b1, elapsed);
        expect_result(4, count);

        // Wrong first note in round 2
        fill_correct(4, count);
        wrong         = (song_ref[0] == 4'd12) ? 4'd1 : song_ref[0] + 4'd1;
        plan_masks[3] = key_mask(wrong);
        count         = 4;
        run_game(4, count, 1'b0, elapsed);
        expect_result(4, count);

        // Restart after the loss
        fill_correct(5, count);
        run_game(5, count, 1'b1, elapsed);
        expect_result(5, count);

        // No key at all
        run_game(4, 0, 1'b0, elapsed);
        expect_result(4, 0);
        if (elapsed < `TIMEOUT_CYCLES || elapsed > `TIMEOUT_CYCLES + 4) begin
            $display("timeout loss came after %0d cycles, outside the window", elapsed);
            errors++;
        end

        // Top key pressed along with each correct key
        fill_correct(3, count);
        for (int k = 0; k < count; k++) begin
            plan_masks[k] = plan_masks[k] | 12'h800;
        end
        run_game(3, count, 1'b1, elapsed);
        expect_result(3, count);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== piano_game.f ====
+incdir+.
piano_pkg.sv
step_if.sv
key_capture.sv
song_mem.sv
game_counters.sv
note_judge.sv
game_fsm.sv
piano_game.sv
tb_piano_game.sv

// ==== Makefile ====
# Verilator simulation of the piano game core
TOP = tb_piano_game

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f piano_game.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
